// File: logic/wadj_pkg.sv
// segment constants and stream structs; NUM_SEG is valid for 2, 4 and 8 only, segments are 8 bytes
package wadj_pkg;

   // ------------------------------
   // segment geometry
   // ------------------------------
   localparam int SEG_BYTES = 8;
   localparam int SEG_W     = SEG_BYTES * 8;
   localparam int NUM_SEG   = 4;                    // egress segments per word
   localparam int SLOT_W    = $clog2(NUM_SEG);
   localparam int TID_W     = 3;

   // ------------------------------
   // stream payloads
   // ------------------------------

   // one narrow ingress beat
   typedef struct packed {
      logic [SEG_W-1:0]     data;
      logic [SEG_BYTES-1:0] keep;
      logic [TID_W-1:0]     tid;
      logic                 err;
      logic                 last;
   } igr_beat_t;

   // one packed egress word, slot 0 in the low segment
   typedef struct packed {
      logic [NUM_SEG-1:0][SEG_W-1:0]     data;
      logic [NUM_SEG-1:0][SEG_BYTES-1:0] keep;
      logic [TID_W-1:0]                  tid;     // from the beat in slot 0
      logic                              err;     // or of all beats in the word
      logic                              last;
   } egr_word_t;

   // egress packet flags
   typedef struct packed {
      logic sop;
      logic eop;
   } pkt_info_t;

endpackage

// File: logic/wadj_fifo.sv
// show-ahead sync FIFO, head valid whenever empty_o is low; caller must not push when full
module wadj_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 16,
   localparam int PTR_W = $clog2(DEPTH),
   localparam int CNT_W = $clog2(DEPTH + 1)
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             push_i,
   input  logic [WIDTH-1:0] din_i,
   input  logic             pop_i,
   output logic [WIDTH-1:0] dout_o,
   output logic             empty_o,
   output logic [CNT_W-1:0] count_o
);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;

   // wrap explicitly so DEPTH need not be a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // ------------------------------
   // storage
   // ------------------------------
   always_ff @(posedge clk) begin
      if (push_i) begin
         mem[wr_ptr_q] <= din_i;
      end
   end

   // ------------------------------
   // pointers and fill count
   // ------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr_q <= ptr_inc(wr_ptr_q);
         end
         if (pop_i) begin
            rd_ptr_q <= ptr_inc(rd_ptr_q);
         end
         case ({push_i, pop_i})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;     // both or neither
         endcase
      end
   end

   assign dout_o  = mem[rd_ptr_q];   // head always presented
   assign empty_o = (count_q == '0);
   assign count_o = count_q;

   // upstream watermark has to keep us from ever filling up
   a_no_overflow: assert property (@(posedge clk) disable iff (rst)
      push_i |-> count_q != CNT_W'(DEPTH));

   // consumer may only pop a presented head
   a_no_underflow: assert property (@(posedge clk) disable iff (rst)
      pop_i |-> !empty_o);

endmodule

// File: logic/wadj_igr_ctrl.sv
// ingress control; tready_o lags the fill count by one cycle so the FIFO needs 4 spare entries
module wadj_igr_ctrl #(
   parameter int IFIFO_DEPTH = 64,
   localparam int CNT_W = $clog2(IFIFO_DEPTH + 1)
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             tvalid_i,
   input  logic             last_i,
   input  logic [CNT_W-1:0] count_i,
   output logic             tready_o,
   output logic             push_o,
   output logic             sop_o
);

   logic ready_q;    // watermark ready
   logic in_pkt_q;   // 0 idle, 1 inside a packet

   // ------------------------------
   // watermark and packet state
   // ------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         ready_q  <= 1'b0;
         in_pkt_q <= 1'b0;
      end else begin
         ready_q <= (count_i < CNT_W'(IFIFO_DEPTH - 4));
         if (push_o) begin
            in_pkt_q <= !last_i;   // last beat closes the packet
         end
      end
   end

   assign tready_o = ready_q;
   assign push_o   = tvalid_i & ready_q;
   assign sop_o    = push_o & !in_pkt_q;   // first beat of a packet

endmodule

// File: logic/wadj_slot_cnt.sv
// slot steering; pops only with 2 spare egress entries, covering the word still in the packer
module wadj_slot_cnt
   import wadj_pkg::*;
#(
   parameter int EFIFO_DEPTH = 16,
   localparam int CNT_W = $clog2(EFIFO_DEPTH + 1)
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              empty_i,
   input  logic              last_i,
   input  logic [CNT_W-1:0]  ecount_i,
   output logic              pop_o,
   output logic [SLOT_W-1:0] slot_o,
   output logic              flush_o
);

   logic [SLOT_W-1:0] slot_q;
   logic              final_slot;

   assign final_slot = (slot_q == SLOT_W'(NUM_SEG - 1));

   // ------------------------------
   // pop and flush decision
   // ------------------------------
   assign pop_o   = !empty_i && (ecount_i < CNT_W'(EFIFO_DEPTH - 2));
   assign flush_o = pop_o && (last_i || final_slot);   // word full or packet done

   always_ff @(posedge clk) begin
      if (rst) begin
         slot_q <= '0;
      end else if (flush_o) begin
         slot_q <= '0;            // next packet starts a fresh word
      end else if (pop_o) begin
         slot_q <= slot_q + 1'b1;
      end
   end

   assign slot_o = slot_q;

endmodule

// File: logic/wadj_seg_packer.sv
// packer register; word and push follow the flushing pop by one cycle, unused slots are zero
module wadj_seg_packer
   import wadj_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              pop_i,
   input  logic [SLOT_W-1:0] slot_i,
   input  logic              flush_i,
   input  igr_beat_t         beat_i,
   output logic              push_o,
   output egr_word_t         word_o
);

   egr_word_t work_q;    // word under construction
   egr_word_t merged;    // work_q with the head beat written in
   egr_word_t word_q;
   logic      push_q;

   // ------------------------------
   // merge head beat into its slot
   // ------------------------------
   always_comb begin
      merged              = work_q;
      merged.data[slot_i] = beat_i.data;
      merged.keep[slot_i] = beat_i.keep;
      merged.err          = work_q.err | beat_i.err;
      merged.last         = beat_i.last;
      if (slot_i == '0) begin
         merged.tid = beat_i.tid;   // first beat names the word
      end
   end

   // working register starts out zero so unwritten slots stay clean
   always_ff @(posedge clk) begin
      if (rst) begin
         work_q <= '0;
         push_q <= 1'b0;
      end else begin
         push_q <= pop_i & flush_i;
         if (pop_i) begin
            if (flush_i) begin
               work_q <= '0;
            end else begin
               work_q <= merged;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (pop_i && flush_i) begin
         word_q <= merged;   // finished word
      end
   end

   assign push_o = push_q;
   assign word_o = word_q;

endmodule

// File: logic/wadj_egr_fmt.sv
// egress formatter, output comb from the FIFO head; BYTE_ROTATE swaps the data bytes only
module wadj_egr_fmt
   import wadj_pkg::*;
#(
   parameter int BYTE_ROTATE = 0
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      empty_i,
   input  egr_word_t word_i,
   input  logic      tready_i,
   output logic      pop_o,
   output logic      tvalid_o,
   output egr_word_t word_o,
   output pkt_info_t info_o
);

   localparam int WORD_BYTES = NUM_SEG * SEG_BYTES;

   logic open_q;   // a packet has started but not ended

   // byte 0 swaps with the top byte of the whole word
   function automatic logic [WORD_BYTES*8-1:0] byte_rev(input logic [WORD_BYTES*8-1:0] d);
      logic [WORD_BYTES*8-1:0] r;
      for (int i = 0; i < WORD_BYTES; i++) begin
         r[i*8 +: 8] = d[(WORD_BYTES - 1 - i)*8 +: 8];
      end
      return r;
   endfunction

   // ------------------------------
   // handshake and packet state
   // ------------------------------
   assign tvalid_o = !empty_i;
   assign pop_o    = tvalid_o & tready_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         open_q <= 1'b0;
      end else if (pop_o) begin
         open_q <= !word_i.last;
      end
   end

   always_comb begin
      word_o = word_i;
      if (BYTE_ROTATE != 0) begin
         word_o.data = byte_rev(word_i.data);   // keep stays in slot order
      end
      info_o.sop = tvalid_o & !open_q;
      info_o.eop = word_i.last;
   end

   // head held in the egress FIFO until taken
   a_hold_word: assert property (@(posedge clk) disable iff (rst)
      tvalid_o && !tready_i |=> tvalid_o && $stable(word_o));

endmodule

// File: logic/wadj_top.sv
// narrow to wide stream packer, one 64-bit beat in, NUM_SEG segments out; FIFO depths at least 8 and 4
module wadj_top
   import wadj_pkg::*;
#(
   parameter int IFIFO_DEPTH = 64,
   parameter int EFIFO_DEPTH = 16,
   parameter int BYTE_ROTATE = 0
) (
   input  logic      clk,
   input  logic      rst,
   // ingress stream
   input  logic      tvalid_i,
   input  igr_beat_t beat_i,
   output logic      tready_o,
   output logic      sop_o,
   // egress stream
   input  logic      tready_i,
   output logic      tvalid_o,
   output egr_word_t word_o,
   output pkt_info_t info_o
);

   localparam int ICNT_W = $clog2(IFIFO_DEPTH + 1);
   localparam int ECNT_W = $clog2(EFIFO_DEPTH + 1);

   // ------------------------------
   // ingress side
   // ------------------------------
   logic              ififo_push;
   logic              ififo_pop;
   logic              ififo_empty;
   logic [ICNT_W-1:0] ififo_count;
   igr_beat_t         head_beat;

   // ------------------------------
   // packing and egress side
   // ------------------------------
   logic [SLOT_W-1:0] slot;
   logic              flush;
   logic              efifo_push;
   logic              efifo_pop;
   logic              efifo_empty;
   logic [ECNT_W-1:0] efifo_count;
   egr_word_t         packed_word;
   egr_word_t         efifo_head;

   wadj_igr_ctrl #(
      .IFIFO_DEPTH (IFIFO_DEPTH)
   ) u_igr_ctrl (
      .clk      (clk),
      .rst      (rst),
      .tvalid_i (tvalid_i),
      .last_i   (beat_i.last),
      .count_i  (ififo_count),
      .tready_o (tready_o),
      .push_o   (ififo_push),
      .sop_o    (sop_o)
   );

   wadj_fifo #(
      .WIDTH ($bits(igr_beat_t)),
      .DEPTH (IFIFO_DEPTH)
   ) u_ififo (
      .clk     (clk),
      .rst     (rst),
      .push_i  (ififo_push),
      .din_i   (beat_i),
      .pop_i   (ififo_pop),
      .dout_o  (head_beat),
      .empty_o (ififo_empty),
      .count_o (ififo_count)
   );

   wadj_slot_cnt #(
      .EFIFO_DEPTH (EFIFO_DEPTH)
   ) u_slot_cnt (
      .clk      (clk),
      .rst      (rst),
      .empty_i  (ififo_empty),
      .last_i   (head_beat.last),
      .ecount_i (efifo_count),
      .pop_o    (ififo_pop),
      .slot_o   (slot),
      .flush_o  (flush)
   );

   wadj_seg_packer u_seg_packer (
      .clk     (clk),
      .rst     (rst),
      .pop_i   (ififo_pop),
      .slot_i  (slot),
      .flush_i (flush),
      .beat_i  (head_beat),
      .push_o  (efifo_push),
      .word_o  (packed_word)
   );

   wadj_fifo #(
      .WIDTH ($bits(egr_word_t)),
      .DEPTH (EFIFO_DEPTH)
   ) u_efifo (
      .clk     (clk),
      .rst     (rst),
      .push_i  (efifo_push),
      .din_i   (packed_word),
      .pop_i   (efifo_pop),
      .dout_o  (efifo_head),
      .empty_o (efifo_empty),
      .count_o (efifo_count)
   );

   wadj_egr_fmt #(
      .BYTE_ROTATE (BYTE_ROTATE)
   ) u_egr_fmt (
      .clk      (clk),
      .rst      (rst),
      .empty_i  (efifo_empty),
      .word_i   (efifo_head),
      .tready_i (tready_i),
      .pop_o    (efifo_pop),
      .tvalid_o (tvalid_o),
      .word_o   (word_o),
      .info_o   (info_o)
   );

endmodule

// File: test/wadj_tb.sv
// testbench for wadj_top with BYTE_ROTATE 1 and depths 16/4; needs NUM_SEG of 2, 4 or 8
module wadj_tb
   import wadj_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_PKT = 40;
   localparam int WORD_BYTES = NUM_SEG * SEG_BYTES;

   logic      clk = 1'b0;
   logic      rst;
   logic      tvalid_i;
   igr_beat_t beat_i;
   logic      tready_o;
   logic      sop_o;
   logic      tready_i;
   logic      tvalid_o;
   egr_word_t word_o;
   pkt_info_t info_o;

   integer    seed;
   igr_beat_t sent_q[$];       // every beat, in send order
   int        pkt_len[$];
   egr_word_t exp_word_q[$];
   pkt_info_t exp_info_q[$];
   bit        ready_pat[];     // egress ready per cycle after reset
   int        limit;
   int        cycle_cnt;
   int        beats_in;
   logic      in_pkt_exp;      // ingress packet open, as the stimulus sees it
   logic      held_valid;
   egr_word_t held_word;
   logic      tready_dropped;

   wadj_top #(
      .IFIFO_DEPTH (16),
      .EFIFO_DEPTH (4),
      .BYTE_ROTATE (1)
   ) u_wadj_top (
      .clk      (clk),
      .rst      (rst),
      .tvalid_i (tvalid_i),
      .beat_i   (beat_i),
      .tready_o (tready_o),
      .sop_o    (sop_o),
      .tready_i (tready_i),
      .tvalid_o (tvalid_o),
      .word_o   (word_o),
      .info_o   (info_o)
   );

   initial begin
      forever #50 clk = ~clk;
   end

   // ------------------------------
   // reporting and compare tasks
   // ------------------------------
   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_word(input egr_word_t got, input egr_word_t exp, input string what);
      if (got !== exp) begin
         fail_run($sformatf("error at %0t: %s\n  got %h\n  exp %h", $time, what, got, exp));
      end
   endtask

   task automatic check_info(input pkt_info_t got, input pkt_info_t exp);
      if (got !== exp) begin
         fail_run($sformatf("error at %0t: info_o sop/eop got %b%b exp %b%b",
                            $time, got.sop, got.eop, exp.sop, exp.eop));
      end
   endtask

   task automatic check_sop(input logic got, input logic exp);
      if (got !== exp) begin
         fail_run($sformatf("error at %0t: sop_o got %b exp %b", $time, got, exp));
      end
   endtask

   // expected word from cnt beats starting at sent_q[first]
   function automatic egr_word_t pack_word(input int first, input int cnt);
      egr_word_t             w;
      logic [WORD_BYTES*8-1:0] flat;
      igr_beat_t             b;
      int                    pos;
      w    = '0;
      flat = '0;
      for (int s = 0; s < cnt; s++) begin
         b = sent_q[first + s];
         for (int i = 0; i < SEG_BYTES; i++) begin
            pos = WORD_BYTES - 1 - (s * SEG_BYTES + i);   // mirrored over the whole word
            flat[pos*8 +: 8] = b.data[i*8 +: 8];
         end
         w.keep[s] = b.keep;   // keep stays in slot order
         w.err     = w.err | b.err;
      end
      w.data = flat;
      w.tid  = sent_q[first].tid;
      w.last = sent_q[first + cnt - 1].last;
      return w;
   endfunction

   // ------------------------------
   // ingress driver
   // ------------------------------
   task automatic idle_cycle();
      tvalid_i = 1'b0;
      @(posedge clk);
      #10;
   endtask

   task automatic send_beat(input igr_beat_t b);
      logic taken;
      tvalid_i = 1'b1;
      beat_i   = b;
      taken    = 1'b0;
      while (!taken) begin
         @(negedge clk);
         taken = tready_o;   // stable until the next rising edge
         @(posedge clk);
         #10;
      end
      tvalid_i = 1'b0;
   endtask

   initial begin
      int        first;
      int        len;
      int        nwords;
      int        cnt;
      igr_beat_t b;
      pkt_info_t inf;
      seed     = 32'hbdfd;
      rst      = 1'b1;
      tvalid_i = 1'b0;
      beat_i   = '0;
      for (int p = 0; p < NUM_PKT; p++) begin
         len = 1 + (($random(seed) & 32'h7fff_ffff) % 11);
         pkt_len.push_back(len);
         for (int k = 0; k < len; k++) begin
            b.data = {$random(seed), $random(seed)};
            b.keep = SEG_BYTES'($random(seed));
            b.tid  = TID_W'($random(seed));
            b.err  = (($random(seed) & 7) == 0);
            b.last = (k == len - 1);
            sent_q.push_back(b);
         end
      end
      first = 0;
      foreach (pkt_len[p]) begin
         nwords = (pkt_len[p] + NUM_SEG - 1) / NUM_SEG;
         for (int k = 0; k < nwords; k++) begin
            cnt = pkt_len[p] - k * NUM_SEG;
            if (cnt > NUM_SEG) begin
               cnt = NUM_SEG;
            end
            exp_word_q.push_back(pack_word(first + k * NUM_SEG, cnt));
            inf.sop = (k == 0);
            inf.eop = (k == nwords - 1);
            exp_info_q.push_back(inf);
         end
         first += pkt_len[p];
      end
      limit     = 40 * sent_q.size() + 200;
      ready_pat = new[limit];
      foreach (ready_pat[c]) begin
         if ((c % 250) >= 170) begin
            ready_pat[c] = 1'b0;                       // long egress stall
         end else begin
            ready_pat[c] = (($random(seed) & 3) != 0);
         end
      end
      repeat (16) @(posedge clk);
      #10;
      rst = 1'b0;
      foreach (sent_q[i]) begin
         while (($random(seed) & 3) == 0) begin
            idle_cycle();
         end
         send_beat(sent_q[i]);
      end
      while (exp_word_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (5) @(posedge clk);
      if (!tready_dropped) begin
         $display("tready_o never dropped while the egress side was stalled");
         $display("TB FAILED");
         $fatal(1, "back-pressure did not reach the ingress side");
      end else begin
         $display("TB PASSED");
         $finish;
      end
   end

   // egress ready, from the pattern made before reset
   initial begin
      int c;
      tready_i = 1'b0;
      c        = 0;
      @(negedge rst);
      forever begin
         tready_i = (c < ready_pat.size()) ? ready_pat[c] : 1'b1;
         c++;
         @(posedge clk);
         #10;
      end
   end

   // ------------------------------
   // compare process, sampled mid cycle
   // ------------------------------
   initial begin
      in_pkt_exp     = 1'b0;
      held_valid     = 1'b0;
      held_word      = '0;
      tready_dropped = 1'b0;
      beats_in       = 0;
   end

   always @(negedge clk) begin
      if (rst) begin
         if (tready_o !== 1'b0 || tvalid_o !== 1'b0 || sop_o !== 1'b0) begin
            fail_run($sformatf("error at %0t: outputs not low in reset (%b %b %b)",
                               $time, tready_o, tvalid_o, sop_o));
         end
      end else begin
         if (held_valid) begin
            if (!tvalid_o) begin
               fail_run($sformatf("error at %0t: tvalid_o fell before its word was taken",
                                  $time));
            end
            check_word(word_o, held_word, "stalled word changed");
         end
         // ingress side
         check_sop(sop_o, tvalid_i && tready_o && !in_pkt_exp);
         if (tvalid_i && tready_o) begin
            in_pkt_exp = !beat_i.last;
            beats_in++;
         end
         if (!tready_o && beats_in > 0) begin
            tready_dropped = 1'b1;
         end
         // egress side
         if (tvalid_o && tready_i) begin
            if (exp_word_q.size() == 0) begin
               fail_run($sformatf("error at %0t: word out with none expected", $time));
            end
            check_word(word_o, exp_word_q.pop_front(), "word_o");
            check_info(info_o, exp_info_q.pop_front());
         end
         held_valid = tvalid_o && !tready_i;
         held_word  = word_o;
      end
   end

   // run limit from the number of beats
   initial cycle_cnt = 0;

   always @(posedge clk) begin
      cycle_cnt++;
      if (limit > 0 && cycle_cnt > limit) begin
         fail_run($sformatf("timeout after %0d cycles with %0d words still missing",
                            cycle_cnt, exp_word_q.size()));
      end
   end

endmodule

// File: sim.f
logic/wadj_pkg.sv
logic/wadj_fifo.sv
logic/wadj_igr_ctrl.sv
logic/wadj_slot_cnt.sv
logic/wadj_seg_packer.sv
logic/wadj_egr_fmt.sv
logic/wadj_top.sv
test/wadj_tb.sv

// File: Makefile
# Verilator build for the width adjuster testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module wadj_tb -f sim.f -o wadj_sim
	./obj_dir/wadj_sim | tee /dev/stderr | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
